/* amul_pkg.sv */
`default_nettype none

package amul_pkg;

  // Operand and result widths
  typedef logic [15:0] operand_t;
  typedef logic [31:0] product_t;

  // Operand halves and their 8x8 products
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] quad_t;

  // APB register offsets
  typedef logic [7:0] reg_addr_t;

  localparam reg_addr_t REG_OPA    = 8'h00;
  localparam reg_addr_t REG_OPB    = 8'h04;
  localparam reg_addr_t REG_CTRL   = 8'h08;
  localparam reg_addr_t REG_STATUS = 8'h0C;
  localparam reg_addr_t REG_RESULT = 8'h10;

  // Control FSM
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } ctrl_state_t;

  // Cycles from issue to res_valid
  localparam int PIPE_LAT = 2;

endpackage

`default_nettype wire

/* amul_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface amul_if import amul_pkg::*; ();

  logic     issue;
  operand_t a;
  operand_t b;
  logic     approx;
  logic     res_valid;
  product_t product;

  modport ctrl (
    output issue, a, b, approx,
    input  res_valid, product
  );

  modport pipe (
    input  issue, a, b, approx,
    output res_valid, product
  );

endinterface

`default_nettype wire

/* quadrant_mul8.sv */
`timescale 1ns/1ps
`default_nettype none

module quadrant_mul8 import amul_pkg::*; #(
  parameter int APPROX_ALLOWED = 1
) (
  input  byte_t x,
  input  byte_t y,
  input  logic  approx,
  output quad_t p
);

  quad_t exact;
  quad_t appr;
  logic  t_hh;
  logic  t_hl;
  logic  t_lh;

  // Array form: one AND row per bit of y
  always_comb begin
    exact = '0;
    for (int i = 0; i < 8; i++) begin
      exact = exact + (quad_t'(x & {8{y[i]}}) << i);
    end
  end

  // Top corner only, bits 7 and 6 of each input
  assign t_hh = x[7] & y[7];
  assign t_hl = x[7] & y[6];
  assign t_lh = x[6] & y[7];

  always_comb begin
    appr     = '0;
    appr[15] = t_hh;
    appr[14] = t_hh ^ (t_hl & t_lh) ^ (t_hl | t_lh | t_hh);
  end

  assign p = ((APPROX_ALLOWED != 0) && approx) ? appr : exact;

endmodule

`default_nettype wire

/* cla_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module cla_adder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             cin,
  output logic [WIDTH-1:0] sum,
  output logic             cout
);

  localparam int NG = WIDTH / 4;

  logic [WIDTH-1:0] p;
  logic [WIDTH-1:0] g;
  logic [NG-1:0]    grp_p;
  logic [NG-1:0]    grp_g;
  logic [NG:0]      cc;

  assign p     = a ^ b;
  assign g     = a & b;
  assign cc[0] = cin;
  assign cout  = cc[NG];

  for (genvar k = 0; k < NG; k++) begin : g_grp
    logic [3:0] gp;
    logic [3:0] gg;
    logic [3:0] c;

    assign gp = p[4*k +: 4];
    assign gg = g[4*k +: 4];

    assign grp_p[k] = &gp;
    assign grp_g[k] = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1]) |
                      (gp[3] & gp[2] & gp[1] & gg[0]);

    // Carry into the next group
    assign cc[k+1] = grp_g[k] | (grp_p[k] & cc[k]);

    // Local lookahead inside the group
    assign c[0] = cc[k];
    assign c[1] = gg[0] | (gp[0] & cc[k]);
    assign c[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & cc[k]);
    assign c[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0]) |
                  (gp[2] & gp[1] & gp[0] & cc[k]);

    assign sum[4*k +: 4] = gp ^ c;
  end

endmodule

`default_nettype wire

/* product_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module product_pipe import amul_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  amul_if.pipe   bus
);

  byte_t    a_hi;
  byte_t    a_lo;
  byte_t    b_hi;
  byte_t    b_lo;
  quad_t    ll;
  quad_t    lh;
  quad_t    hl;
  quad_t    hh;
  quad_t    ll_q;
  quad_t    lh_q;
  quad_t    hl_q;
  quad_t    hh_q;
  logic     v1;
  product_t part_sum;
  product_t full_sum;

  assign a_hi = bus.a[15:8];
  assign a_lo = bus.a[7:0];
  assign b_hi = bus.b[15:8];
  assign b_lo = bus.b[7:0];

  quadrant_mul8 #(.APPROX_ALLOWED(1)) mul_ll (.x(a_lo), .y(b_lo), .approx(bus.approx), .p(ll));
  quadrant_mul8 #(.APPROX_ALLOWED(1)) mul_lh (.x(a_lo), .y(b_hi), .approx(bus.approx), .p(lh));
  quadrant_mul8 #(.APPROX_ALLOWED(1)) mul_hl (.x(a_hi), .y(b_lo), .approx(bus.approx), .p(hl));
  // High quadrant carries most of the weight, kept exact
  quadrant_mul8 #(.APPROX_ALLOWED(0)) mul_hh (.x(a_hi), .y(b_hi), .approx(bus.approx), .p(hh));

  // Stage 1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v1 <= 1'b0;
    end else begin
      v1 <= bus.issue;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.issue) begin
      ll_q <= ll;
      lh_q <= lh;
      hl_q <= hl;
      hh_q <= hh;
    end
  end

  // HH:LL plus both cross products at offset 8
  cla_adder #(.WIDTH(32)) add_lh (
    .a    ({hh_q, ll_q}),
    .b    ({8'h00, lh_q, 8'h00}),
    .cin  (1'b0),
    .sum  (part_sum),
    .cout ()
  );

  cla_adder #(.WIDTH(32)) add_hl (
    .a    (part_sum),
    .b    ({8'h00, hl_q, 8'h00}),
    .cin  (1'b0),
    .sum  (full_sum),
    .cout ()
  );

  // Stage 2
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus.res_valid <= 1'b0;
    end else begin
      bus.res_valid <= v1;
    end
  end

  always_ff @(posedge clk) begin
    if (v1) begin
      bus.product <= full_sum;
    end
  end

endmodule

`default_nettype wire

/* amul_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module amul_ctrl import amul_pkg::*; #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              irq,
  amul_if.ctrl              bus
);

  ctrl_state_t state;
  operand_t    opa;
  operand_t    opb;
  logic        approx_q;
  product_t    result;
  logic        access;
  logic        mapped;
  logic        hit_ctrl;
  logic        start_req;
  logic        start_ok;
  logic        wr_ok;
  logic        busy;
  logic        done;
  logic [31:0] rd_val;

  assign busy = (state == BUSY);
  assign done = (state == DONE);
  assign irq  = done;

  // APB access phase, always zero wait
  assign access    = psel & penable;
  assign pready    = 1'b1;
  assign hit_ctrl  = (paddr == ADDR_W'(REG_CTRL));
  assign start_req = access & pwrite & hit_ctrl & pwdata[0];
  assign pslverr   = access & (~mapped | (start_req & busy));
  assign wr_ok     = access & pwrite & ~pslverr;
  assign start_ok  = start_req & ~pslverr;

  always_comb begin
    mapped = 1'b1;
    rd_val = '0;
    case (paddr)
      ADDR_W'(REG_OPA):    rd_val = {16'h0000, opa};
      ADDR_W'(REG_OPB):    rd_val = {16'h0000, opb};
      ADDR_W'(REG_CTRL):   rd_val = {30'h0, approx_q, 1'b0};
      ADDR_W'(REG_STATUS): rd_val = {30'h0, done, busy};
      ADDR_W'(REG_RESULT): rd_val = result;
      default:             mapped = 1'b0;
    endcase
  end

  assign prdata = (access && !pwrite && !pslverr) ? rd_val : '0;

  // Operands and mode go straight to the pipeline
  assign bus.a      = opa;
  assign bus.b      = opb;
  assign bus.approx = approx_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      opa      <= '0;
      opb      <= '0;
      approx_q <= 1'b0;
    end else if (wr_ok) begin
      case (paddr)
        ADDR_W'(REG_OPA):  opa <= pwdata[15:0];
        ADDR_W'(REG_OPB):  opb <= pwdata[15:0];
        ADDR_W'(REG_CTRL): approx_q <= pwdata[1];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result <= '0;
    end else if (bus.res_valid) begin
      result <= bus.product;
    end
  end

  // Issue goes out the cycle after the start write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus.issue <= 1'b0;
    end else begin
      bus.issue <= start_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (start_ok) begin
            state <= BUSY;
          end
        end
        BUSY: begin
          if (bus.res_valid) begin
            state <= DONE;
          end
        end
        DONE: begin
          // A new start clears done and irq
          if (start_ok) begin
            state <= BUSY;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* amul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module amul_top #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              irq
);

  amul_if bus0 ();

  amul_ctrl #(.ADDR_W(ADDR_W)) ctrl0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .irq     (irq),
    .bus     (bus0.ctrl)
  );

  product_pipe pipe0 (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus0.pipe)
  );

endmodule

`default_nettype wire

/* amul_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module amul_checker import amul_pkg::*; #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [31:0]       pwdata,
  input  logic [31:0]       prdata,
  input  logic              pready,
  input  logic              pslverr,
  input  logic              irq,
  output int                errors,
  output int                checks
);

  operand_t    opa_m;
  operand_t    opb_m;
  logic        approx_m;
  logic        busy_m;
  logic        done_m;
  int          cnt;
  product_t    res_m;
  product_t    pend_m;
  logic        access;
  logic        mapped;
  logic        start_m;
  logic        err_m;
  logic [31:0] exp_rd;

  // One 8x8 quadrant in exact or top-corner form
  function automatic quad_t corner_quad(input byte_t x, input byte_t y, input logic appr);
    logic  hh;
    logic  hl;
    logic  lh;
    quad_t q;
    hh = x[7] & y[7];
    hl = x[7] & y[6];
    lh = x[6] & y[7];
    if (appr) begin
      q     = '0;
      q[15] = hh;
      q[14] = hh ^ (hl & lh) ^ (hl | lh | hh);
    end else begin
      q = quad_t'(x) * quad_t'(y);
    end
    return q;
  endfunction

  function automatic product_t ref_product(input operand_t a, input operand_t b,
                                           input logic appr);
    quad_t ll;
    quad_t lh;
    quad_t hl;
    quad_t hh;
    ll = corner_quad(a[7:0], b[7:0], appr);
    lh = corner_quad(a[7:0], b[15:8], appr);
    hl = corner_quad(a[15:8], b[7:0], appr);
    hh = corner_quad(a[15:8], b[15:8], 1'b0);
    return {hh, ll} + (product_t'(lh) << 8) + (product_t'(hl) << 8);
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    errors++;
    $display("[FAIL] %0t %s expected %h actual %h", $time, sig, exp_v, act_v);
  endtask

  always_comb begin
    access = psel & penable;
    mapped = 1'b1;
    exp_rd = '0;
    case (paddr)
      ADDR_W'(REG_OPA):    exp_rd = {16'h0000, opa_m};
      ADDR_W'(REG_OPB):    exp_rd = {16'h0000, opb_m};
      ADDR_W'(REG_CTRL):   exp_rd = {30'h0, approx_m, 1'b0};
      ADDR_W'(REG_STATUS): exp_rd = {30'h0, done_m, busy_m};
      ADDR_W'(REG_RESULT): exp_rd = res_m;
      default:             mapped = 1'b0;
    endcase
    start_m = access & pwrite & (paddr == ADDR_W'(REG_CTRL)) & pwdata[0];
    err_m   = access & (~mapped | (start_m & busy_m));
  end

  // Register and status model with the result due PIPE_LAT + 1 edges after start
  always @(posedge clk) begin
    if (!rst_n) begin
      opa_m    <= '0;
      opb_m    <= '0;
      approx_m <= 1'b0;
      busy_m   <= 1'b0;
      done_m   <= 1'b0;
      cnt      <= 0;
      res_m    <= '0;
      pend_m   <= '0;
    end else begin
      if (access && pwrite && !err_m) begin
        case (paddr)
          ADDR_W'(REG_OPA):  opa_m <= pwdata[15:0];
          ADDR_W'(REG_OPB):  opb_m <= pwdata[15:0];
          ADDR_W'(REG_CTRL): approx_m <= pwdata[1];
          default: ;
        endcase
      end
      if (start_m && !err_m) begin
        busy_m <= 1'b1;
        done_m <= 1'b0;
        cnt    <= PIPE_LAT;
        pend_m <= ref_product(opa_m, opb_m, pwdata[1]);
      end else if (busy_m) begin
        if (cnt == 0) begin
          busy_m <= 1'b0;
          done_m <= 1'b1;
          res_m  <= pend_m;
        end else begin
          cnt <= cnt - 1;
        end
      end
    end
  end

  // Pre-edge values of DUT and model are compared here
  always @(posedge clk) begin
    if (!rst_n) begin
      errors = 0;
      checks = 0;
    end else begin
      checks++;
      if (irq !== done_m) report_mismatch("irq", 32'(done_m), 32'(irq));
      if (access) begin
        checks++;
        if (pready !== 1'b1) report_mismatch("pready", 32'h1, 32'(pready));
        if (pslverr !== err_m) report_mismatch("pslverr", 32'(err_m), 32'(pslverr));
        if (!pwrite) begin
          checks++;
          if (prdata !== (err_m ? 32'h0 : exp_rd)) begin
            report_mismatch($sformatf("prdata[%h]", paddr), err_m ? 32'h0 : exp_rd, prdata);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* amul_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module amul_tb import amul_pkg::*; ();

  localparam int ADDR_W   = 8;
  localparam int WAIT_MAX = 20;

  logic              clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic              irq;
  int                chk_errors;
  int                chk_checks;
  int                timeouts;
  int                test_num;
  int                err_mark;
  operand_t          op_a;
  operand_t          op_b;

  amul_top #(.ADDR_W(ADDR_W)) dut0 (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .irq(irq)
  );

  amul_checker #(.ADDR_W(ADDR_W)) chk0 (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .irq(irq), .errors(chk_errors), .checks(chk_checks)
  );

  always #50 clk = ~clk;

  // Setup phase on one falling edge, access phase on the next
  task automatic apb_access(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [31:0] data);
    int n;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    n = 0;
    @(posedge clk);
    while (!pready && n < WAIT_MAX) begin
      @(posedge clk);
      n++;
    end
    if (!pready) begin
      $display("APB transfer to address %h never completed", addr);
      timeouts++;
    end
  endtask

  task automatic bus_idle();
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    bus_idle();
    while (!irq && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (!irq) begin
      $display("Timed out at %0t waiting for irq after a start", $time);
      timeouts++;
    end
  endtask

  task automatic run_op(input operand_t a, input operand_t b, input logic appr);
    apb_access(1'b1, REG_OPA, {16'h0000, a});
    apb_access(1'b1, REG_OPB, {16'h0000, b});
    apb_access(1'b1, REG_CTRL, {30'h0, appr, 1'b1});
    wait_irq();
    apb_access(1'b0, REG_RESULT, 32'h0);
  endtask

  task automatic end_test(input string name);
    int now;
    bus_idle();
    now = chk_errors + timeouts;
    $display("test %0d %-20s %s (%0d errors)", test_num, name,
             (now == err_mark) ? "ok" : "failed", now - err_mark);
    err_mark = now;
    test_num++;
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    timeouts = 0;
    test_num = 1;
    err_mark = 0;
    void'($urandom(32'hd3fe_4c00));
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    apb_access(1'b0, REG_STATUS, 32'h0);
    apb_access(1'b0, REG_RESULT, 32'h0);
    apb_access(1'b0, REG_OPA, 32'h0);
    apb_access(1'b0, REG_OPB, 32'h0);
    apb_access(1'b0, REG_CTRL, 32'h0);
    end_test("reset values");

    run_op(16'h0000, 16'h1234, 1'b0);
    run_op(16'h0001, 16'hbeef, 1'b0);
    run_op(16'hffff, 16'hffff, 1'b0);
    for (int i = 0; i < 200; i++) begin
      run_op(operand_t'($urandom()), operand_t'($urandom()), 1'b0);
    end
    end_test("exact products");

    // Every pattern of bits 7 and 6 in both low bytes
    for (int i = 0; i < 16; i++) begin
      op_a = operand_t'($urandom());
      op_b = operand_t'($urandom());
      op_a[7:6] = i[3:2];
      op_b[7:6] = i[1:0];
      run_op(op_a, op_b, 1'b1);
    end
    for (int i = 0; i < 200; i++) begin
      run_op(operand_t'($urandom()), operand_t'($urandom()), 1'b1);
    end
    apb_access(1'b0, REG_CTRL, 32'h0);
    end_test("approximate products");

    apb_access(1'b1, REG_OPA, 32'h0000_00c3);
    apb_access(1'b1, REG_OPB, 32'h0000_7e51);
    apb_access(1'b1, REG_CTRL, 32'h0000_0001);
    apb_access(1'b0, REG_STATUS, 32'h0);
    // First read that can see the new product
    apb_access(1'b0, REG_RESULT, 32'h0);
    wait_irq();
    apb_access(1'b0, REG_STATUS, 32'h0);
    apb_access(1'b1, REG_CTRL, 32'h0000_0001);
    apb_access(1'b0, REG_STATUS, 32'h0);
    wait_irq();
    apb_access(1'b0, REG_RESULT, 32'h0);
    end_test("status sequencing");

    apb_access(1'b1, REG_OPA, 32'h0000_a5f0);
    apb_access(1'b1, REG_OPB, 32'h0000_0f3c);
    apb_access(1'b1, REG_CTRL, 32'h0000_0001);
    apb_access(1'b1, REG_CTRL, 32'h0000_0003);
    apb_access(1'b0, 8'h14, 32'h0);
    apb_access(1'b1, 8'h20, 32'hdead_beef);
    wait_irq();
    apb_access(1'b0, REG_RESULT, 32'h0);
    apb_access(1'b0, REG_CTRL, 32'h0);
    apb_access(1'b0, REG_OPA, 32'h0);
    apb_access(1'b0, REG_OPB, 32'h0);
    end_test("error responses");

    $display("%0d tests, %0d checks, %0d errors, %0d timeouts",
             test_num - 1, chk_checks, chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
amul_pkg.sv
amul_if.sv
quadrant_mul8.sv
cla_adder.sv
product_pipe.sv
amul_ctrl.sv
amul_top.sv
amul_checker.sv
amul_tb.sv
